/* flist.f */
logic/hockey_game_pkg.sv
logic/hockey_display_pkg.sv
logic/player_input_stage.sv
logic/puck_tracker.sv
logic/rally_controller.sv
logic/scoreboard_display.sv
logic/hockey_top.sv
verification/hockey_sva.sv
verification/hockey_tb.sv

/* logic/hockey_display_pkg.sv */
`default_nettype none

package hockey_display_pkg;

    // active low, bit 6 is segment a, bit 0 is segment g
    typedef logic [6:0] seg_t;
    typedef logic [4:0] led_bar_t;

    localparam seg_t seg_blank = 7'b1111111;
    localparam seg_t seg_dash  = 7'b1111110;
    localparam seg_t seg_a     = 7'b0001000;
    localparam seg_t seg_b     = 7'b1100000;

    typedef struct packed {
        seg_t row_digit;
        seg_t score_a_digit;
        seg_t sep_digit;
        seg_t score_b_digit;
    } ssd_bank_t;

    localparam ssd_bank_t ssd_blank = '{seg_blank, seg_blank, seg_blank, seg_blank};
    localparam ssd_bank_t ssd_idle  = '{seg_blank, seg_a, seg_dash, seg_b};

    localparam led_bar_t bar_full = 5'b11111;
    localparam led_bar_t bar_even = 5'b10101;
    localparam led_bar_t bar_odd  = 5'b01010;

    function automatic seg_t seg_digit(input logic [2:0] value);
        case (value)
            3'd0: return 7'b0000001;
            3'd1: return 7'b1001111;
            3'd2: return 7'b0010010;
            3'd3: return 7'b0000110;
            3'd4: return 7'b1001100;
            default: return seg_dash;
        endcase
    endfunction

    // column 0 sits on the leftmost LED
    function automatic led_bar_t bar_at(input logic [2:0] col);
        return led_bar_t'(5'b10000 >> col);
    endfunction

endpackage

`default_nettype wire

/* logic/hockey_game_pkg.sv */
`default_nettype none

package hockey_game_pkg;

    // square field, rows and columns alike
    localparam int field_size = 5;

    typedef logic [2:0] coord_t;
    typedef logic [1:0] dir_t;
    typedef logic [1:0] score_t;

    localparam coord_t max_coord = coord_t'(field_size - 1);

    // 2'b11 behaves as straight
    localparam dir_t dir_straight = 2'b00;
    localparam dir_t dir_rising   = 2'b01;
    localparam dir_t dir_falling  = 2'b10;

    typedef enum logic {
        side_a = 1'b0,
        side_b = 1'b1
    } player_t;

    typedef enum logic [2:0] {
        phase_idle       = 3'd0,
        phase_show_score = 3'd1,
        phase_serve      = 3'd2,
        phase_travel     = 3'd3,
        phase_respond    = 3'd4,
        phase_goal       = 3'd5,
        phase_game_over  = 3'd6
    } phase_t;

    typedef struct packed {
        logic   press;
        coord_t row;
        dir_t   dir;
        logic   row_ok;
    } paddle_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        dir_t   dir;
    } puck_t;

    // side is server, receiver, scorer or winner depending on phase
    typedef struct packed {
        phase_t  phase;
        player_t side;
        puck_t   puck;
        score_t  score_a;
        score_t  score_b;
        logic    blink;
    } game_status_t;

    function automatic player_t opponent(input player_t p);
        return (p == side_a) ? side_b : side_a;
    endfunction

    // A defends column 0, B the last column
    function automatic coord_t goal_col(input player_t p);
        return (p == side_a) ? coord_t'(0) : max_coord;
    endfunction

endpackage

`default_nettype wire

/* logic/hockey_top.sv */
`default_nettype none

module hockey_top #(
    parameter int tick_count = 100,
    parameter int win_score  = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          btn_a,
    input  logic                          btn_b,
    input  hockey_game_pkg::dir_t         dir_a,
    input  hockey_game_pkg::dir_t         dir_b,
    input  hockey_game_pkg::coord_t       y_a,
    input  hockey_game_pkg::coord_t       y_b,
    output logic                          led_a,
    output logic                          led_b,
    output hockey_display_pkg::led_bar_t  led_bar,
    output hockey_display_pkg::ssd_bank_t ssd
);
    import hockey_game_pkg::*;

    paddle_t      paddle_a;
    paddle_t      paddle_b;
    paddle_t      cmd_paddle;
    player_t      cmd_side;
    logic         cmd_serve;
    logic         cmd_step;
    logic         cmd_return;
    puck_t        puck;
    game_status_t status;

    player_input_stage i_input_a (
        .clk    (clk),
        .rst    (rst),
        .btn    (btn_a),
        .row    (y_a),
        .dir    (dir_a),
        .paddle (paddle_a)
    );

    player_input_stage i_input_b (
        .clk    (clk),
        .rst    (rst),
        .btn    (btn_b),
        .row    (y_b),
        .dir    (dir_b),
        .paddle (paddle_b)
    );

    rally_controller #(
        .tick_count (tick_count),
        .win_score  (win_score)
    ) i_rally_controller (
        .clk        (clk),
        .rst        (rst),
        .paddle_a   (paddle_a),
        .paddle_b   (paddle_b),
        .puck       (puck),
        .cmd_serve  (cmd_serve),
        .cmd_step   (cmd_step),
        .cmd_return (cmd_return),
        .cmd_side   (cmd_side),
        .cmd_paddle (cmd_paddle),
        .status     (status)
    );

    puck_tracker i_puck_tracker (
        .clk        (clk),
        .rst        (rst),
        .cmd_serve  (cmd_serve),
        .cmd_step   (cmd_step),
        .cmd_return (cmd_return),
        .side       (cmd_side),
        .paddle     (cmd_paddle),
        .puck       (puck)
    );

    scoreboard_display i_scoreboard_display (
        .clk      (clk),
        .rst      (rst),
        .status   (status),
        .paddle_a (paddle_a),
        .paddle_b (paddle_b),
        .led_a    (led_a),
        .led_b    (led_b),
        .led_bar  (led_bar),
        .ssd      (ssd)
    );

endmodule

`default_nettype wire

/* logic/player_input_stage.sv */
`default_nettype none

module player_input_stage (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     btn,
    input  hockey_game_pkg::coord_t  row,
    input  hockey_game_pkg::dir_t    dir,
    output hockey_game_pkg::paddle_t paddle
);
    import hockey_game_pkg::*;

    // first synchronizer stage
    logic   btn_meta;
    coord_t row_meta;
    dir_t   dir_meta;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            btn_meta <= 1'b0;
            row_meta <= '0;
            dir_meta <= dir_straight;
            paddle   <= '0;
        end
        else
        begin
            btn_meta      <= btn;
            row_meta      <= row;
            dir_meta      <= dir;
            paddle.press  <= btn_meta;
            paddle.row    <= row_meta;
            paddle.dir    <= dir_meta;
            // switch rows 5..7 are off the field
            paddle.row_ok <= (row_meta < field_size);
        end
    end

endmodule

`default_nettype wire

/* logic/puck_tracker.sv */
`default_nettype none

module puck_tracker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_serve,
    input  logic                     cmd_step,
    input  logic                     cmd_return,
    input  hockey_game_pkg::player_t side,
    input  hockey_game_pkg::paddle_t paddle,
    output hockey_game_pkg::puck_t   puck
);
    import hockey_game_pkg::*;

    // one row move, bouncing off rows 0 and max_coord
    function automatic puck_t row_step(input puck_t p, input dir_t d);
        puck_t q;
        q = p;
        case (d)
            dir_rising:
            begin
                if (p.y == max_coord)
                begin
                    q.y   = max_coord - 3'd1;
                    q.dir = dir_falling;
                end
                else
                begin
                    q.y   = p.y + 3'd1;
                    q.dir = dir_rising;
                end
            end
            dir_falling:
            begin
                if (p.y == '0)
                begin
                    q.y   = 3'd1;
                    q.dir = dir_rising;
                end
                else
                begin
                    q.y   = p.y - 3'd1;
                    q.dir = dir_falling;
                end
            end
            default:
                q.dir = dir_straight;
        endcase
        return q;
    endfunction

    puck_t moved;
    puck_t returned;

    // side is the receiver on a step and the returning player on a return
    always_comb
    begin
        moved     = puck;
        moved.x   = (side == side_b) ? puck.x + 3'd1 : puck.x - 3'd1;
        moved     = row_step(moved, puck.dir);
        returned   = puck;
        returned.x = (side == side_b) ? max_coord - 3'd1 : 3'd1;
        returned   = row_step(returned, paddle.dir);
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            puck <= '0;
        else if (cmd_serve)
            puck <= '{x: goal_col(side), y: paddle.row, dir: paddle.dir};
        else if (cmd_return)
            puck <= returned;
        else if (cmd_step)
            puck <= moved;
    end

endmodule

`default_nettype wire

/* logic/rally_controller.sv */
`default_nettype none

module rally_controller #(
    parameter int tick_count = 100,
    parameter int win_score  = 3
) (
    input  logic                          clk,
    input  logic                          rst,
    input  hockey_game_pkg::paddle_t      paddle_a,
    input  hockey_game_pkg::paddle_t      paddle_b,
    input  hockey_game_pkg::puck_t        puck,
    output logic                          cmd_serve,
    output logic                          cmd_step,
    output logic                          cmd_return,
    output hockey_game_pkg::player_t      cmd_side,
    output hockey_game_pkg::paddle_t      cmd_paddle,
    output hockey_game_pkg::game_status_t status
);
    import hockey_game_pkg::*;

    localparam int timer_w = $clog2(tick_count + 2);

    phase_t             phase;
    player_t            side;
    logic [timer_w-1:0] timer;
    score_t             score_a;
    score_t             score_b;
    logic               blink;
    logic               tick;
    logic               arrived;
    logic               hit_ok;
    score_t             scorer_score;

    assign tick = (timer == timer_w'(tick_count));

    // the player named by side always holds the relevant paddle
    assign cmd_side   = side;
    assign cmd_paddle = (side == side_a) ? paddle_a : paddle_b;

    assign arrived      = (puck.x == goal_col(side));
    assign hit_ok       = cmd_paddle.press && (cmd_paddle.row == puck.y);
    assign scorer_score = (side == side_a) ? score_a : score_b;

    assign cmd_serve  = (phase == phase_serve) && cmd_paddle.press && cmd_paddle.row_ok;
    assign cmd_step   = (phase == phase_travel) && tick && !arrived;
    assign cmd_return = (phase == phase_respond) && hit_ok;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            phase   <= phase_idle;
            side    <= side_a;
            timer   <= '0;
            score_a <= '0;
            score_b <= '0;
            blink   <= 1'b0;
        end
        else
        begin
            timer <= tick ? '0 : timer + 1'b1;
            case (phase)
                phase_idle:
                begin
                    timer <= '0;
                    if (paddle_a.press != paddle_b.press)
                    begin
                        phase <= phase_show_score;
                        side  <= paddle_a.press ? side_a : side_b;
                    end
                end
                phase_show_score:
                begin
                    if (tick)
                        phase <= phase_serve;
                end
                phase_serve:
                begin
                    // no time limit here
                    timer <= '0;
                    if (cmd_serve)
                    begin
                        phase <= phase_travel;
                        side  <= opponent(side);
                    end
                end
                phase_travel:
                begin
                    if (arrived)
                    begin
                        phase <= phase_respond;
                        timer <= '0;
                    end
                end
                phase_respond:
                begin
                    if (cmd_return)
                    begin
                        phase <= phase_travel;
                        side  <= opponent(side);
                        timer <= '0;
                    end
                    else if (tick)
                    begin
                        // missed, the other player scores
                        phase <= phase_goal;
                        side  <= opponent(side);
                        if (side == side_a)
                            score_b <= score_b + 1'b1;
                        else
                            score_a <= score_a + 1'b1;
                    end
                end
                phase_goal:
                begin
                    if (tick)
                    begin
                        if (scorer_score == score_t'(win_score))
                            phase <= phase_game_over;
                        else
                        begin
                            phase <= phase_serve;
                            side  <= opponent(side);
                        end
                    end
                end
                phase_game_over:
                begin
                    if (tick)
                        blink <= ~blink;
                end
                default:
                    phase <= phase_idle;
            endcase
        end
    end

    assign status = '{
        phase:   phase,
        side:    side,
        puck:    puck,
        score_a: score_a,
        score_b: score_b,
        blink:   blink
    };

endmodule

`default_nettype wire

/* logic/scoreboard_display.sv */
`default_nettype none

module scoreboard_display (
    input  logic                          clk,
    input  logic                          rst,
    input  hockey_game_pkg::game_status_t status,
    input  hockey_game_pkg::paddle_t      paddle_a,
    input  hockey_game_pkg::paddle_t      paddle_b,
    output logic                          led_a,
    output logic                          led_b,
    output hockey_display_pkg::led_bar_t  led_bar,
    output hockey_display_pkg::ssd_bank_t ssd
);
    import hockey_game_pkg::*;
    import hockey_display_pkg::*;

    logic      led_a_next;
    logic      led_b_next;
    led_bar_t  bar_next;
    ssd_bank_t ssd_next;
    ssd_bank_t ssd_scores;
    coord_t    serve_row;

    assign serve_row = (status.side == side_a) ? paddle_a.row : paddle_b.row;

    // score view shared by show_score, goal and game_over
    always_comb
    begin
        ssd_scores               = ssd_blank;
        ssd_scores.score_a_digit = seg_digit({1'b0, status.score_a});
        ssd_scores.sep_digit     = seg_dash;
        ssd_scores.score_b_digit = seg_digit({1'b0, status.score_b});
    end

    always_comb
    begin
        led_a_next = 1'b0;
        led_b_next = 1'b0;
        bar_next   = '0;
        ssd_next   = ssd_blank;
        case (status.phase)
            phase_idle:
            begin
                led_a_next = 1'b1;
                led_b_next = 1'b1;
                ssd_next   = ssd_idle;
            end
            phase_show_score, phase_goal:
            begin
                bar_next = bar_full;
                ssd_next = ssd_scores;
            end
            phase_serve:
            begin
                led_a_next         = (status.side == side_a);
                led_b_next         = (status.side == side_b);
                ssd_next.row_digit = seg_digit(serve_row);
            end
            phase_travel:
            begin
                bar_next           = bar_at(status.puck.x);
                ssd_next.row_digit = seg_digit(status.puck.y);
            end
            phase_respond:
            begin
                led_a_next         = (status.side == side_a);
                led_b_next         = (status.side == side_b);
                bar_next           = bar_at(goal_col(status.side));
                ssd_next.row_digit = seg_digit(status.puck.y);
            end
            phase_game_over:
            begin
                bar_next           = status.blink ? bar_odd : bar_even;
                ssd_next           = ssd_scores;
                ssd_next.row_digit = (status.side == side_a) ? seg_a : seg_b;
            end
            default:
                ssd_next = ssd_blank;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            led_a   <= 1'b1;
            led_b   <= 1'b1;
            led_bar <= '0;
            ssd     <= ssd_idle;
        end
        else
        begin
            led_a   <= led_a_next;
            led_b   <= led_b_next;
            led_bar <= bar_next;
            ssd     <= ssd_next;
        end
    end

endmodule

`default_nettype wire

/* verification/hockey_sva.sv */
`default_nettype none

module hockey_sva #(
    parameter int win_score = 3
) (
    input logic                          clk,
    input logic                          rst,
    input hockey_display_pkg::led_bar_t  led_bar,
    input hockey_game_pkg::game_status_t status
);
    timeunit 1ns;
    timeprecision 100ps;

    import hockey_game_pkg::*;
    import hockey_display_pkg::*;

    int error_count = 0;

    // dark, one column, full, or one of the two end-of-game patterns
    bar_pattern: assert property (@(posedge clk) disable iff (rst)
        $onehot0(led_bar) || led_bar == bar_full || led_bar == bar_even || led_bar == bar_odd)
    else
    begin
        error_count++;
        $error("led_bar shows an unknown pattern %b", led_bar);
    end

    score_a_no_decrease: assert property (@(posedge clk) disable iff (rst)
        status.score_a >= $past(status.score_a))
    else
    begin
        error_count++;
        $error("score_a went down to %0d", status.score_a);
    end

    score_b_no_decrease: assert property (@(posedge clk) disable iff (rst)
        status.score_b >= $past(status.score_b))
    else
    begin
        error_count++;
        $error("score_b went down to %0d", status.score_b);
    end

    scores_bounded: assert property (@(posedge clk) disable iff (rst)
        int'(status.score_a) <= win_score && int'(status.score_b) <= win_score)
    else
    begin
        error_count++;
        $error("a score is above %0d", win_score);
    end

endmodule

bind hockey_top hockey_sva #(
    .win_score (win_score)
) i_hockey_sva (
    .clk     (clk),
    .rst     (rst),
    .led_bar (led_bar),
    .status  (status)
);

`default_nettype wire

/* verification/hockey_tb.sv */
`default_nettype none

module hockey_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import hockey_game_pkg::*;
    import hockey_display_pkg::*;

    localparam int tick_count = 4;
    localparam int win_score  = 2;
    localparam int wait_limit = 100;

    logic      clk;
    logic      rst;
    logic      btn_a;
    logic      btn_b;
    dir_t      dir_a;
    dir_t      dir_b;
    coord_t    y_a;
    coord_t    y_b;
    logic      led_a;
    logic      led_b;
    led_bar_t  led_bar;
    ssd_bank_t ssd;

    logic [31:0] lfsr = 32'h3e4e;
    int          errors = 0;
    int          checks = 0;
    int          test_errors = 0;
    int          sva_errors;
    logic        timed_out = 1'b0;

    // puck as the testbench expects it
    int   exp_x;
    int   exp_y;
    dir_t exp_dir;
    logic heading_b;
    int   exp_score_a = 0;
    int   exp_score_b = 0;

    hockey_top #(
        .tick_count (tick_count),
        .win_score  (win_score)
    ) i_hockey_top (
        .clk     (clk),
        .rst     (rst),
        .btn_a   (btn_a),
        .btn_b   (btn_b),
        .dir_a   (dir_a),
        .dir_b   (dir_b),
        .y_a     (y_a),
        .y_b     (y_b),
        .led_a   (led_a),
        .led_b   (led_b),
        .led_bar (led_bar),
        .ssd     (ssd)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    function automatic logic [7:0] random_bits(input int n);
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr  = lfsr_step(lfsr);
            value = {value[6:0], lfsr[0]};
        end
        return value;
    endfunction

    // active low, segment a in bit 6
    function automatic seg_t digit_glyph(input int v);
        case (v)
            0: return 7'b0000001;
            1: return 7'b1001111;
            2: return 7'b0010010;
            3: return 7'b0000110;
            4: return 7'b1001100;
            default: return 7'b1111110;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (!timed_out)
        begin
            checks++;
            assert (actual === expected)
            else
            begin
                errors++;
                $display("ERR t=%0t %s: got %0h, expected %0h", $time, name, actual, expected);
            end
        end
    endtask

    task automatic report_timeout(input string what);
        timed_out = 1'b1;
        errors++;
        $display("timeout at %0t while waiting for %s", $time, what);
    endtask

    task automatic wait_bar(input led_bar_t value, input string what);
        int n;
        n = 0;
        while (led_bar !== value && n < wait_limit && !timed_out)
        begin
            @(negedge clk);
            n++;
        end
        if (led_bar !== value && !timed_out)
            report_timeout(what);
    endtask

    task automatic wait_bar_change(input string what);
        led_bar_t prev;
        int       n;
        prev = led_bar;
        n = 0;
        while (led_bar === prev && n < wait_limit && !timed_out)
        begin
            @(negedge clk);
            n++;
        end
        if (led_bar === prev && !timed_out)
            report_timeout(what);
    endtask

    task automatic wait_leds(input logic a, input logic b, input string what);
        int n;
        n = 0;
        while ((led_a !== a || led_b !== b) && n < wait_limit && !timed_out)
        begin
            @(negedge clk);
            n++;
        end
        if ((led_a !== a || led_b !== b) && !timed_out)
            report_timeout(what);
    endtask

    task automatic wait_row_digit(input seg_t value, input string what);
        int n;
        n = 0;
        while (ssd.row_digit !== value && n < wait_limit && !timed_out)
        begin
            @(negedge clk);
            n++;
        end
        if (ssd.row_digit !== value && !timed_out)
            report_timeout(what);
    endtask

    task automatic end_test(input string name);
        $display("test %-10s %s", name, (errors == test_errors) ? "ok" : "failed");
        test_errors = errors;
    endtask

    // bounce off rows 0 and 4, 2'b11 acts as straight
    task automatic row_step_model(input dir_t d);
        case (d)
            2'b01:
            begin
                exp_dir = 2'b01;
                if (exp_y == 4)
                begin
                    exp_y   = 3;
                    exp_dir = 2'b10;
                end
                else
                    exp_y++;
            end
            2'b10:
            begin
                exp_dir = 2'b10;
                if (exp_y == 0)
                begin
                    exp_y   = 1;
                    exp_dir = 2'b01;
                end
                else
                    exp_y--;
            end
            default:
                exp_dir = 2'b00;
        endcase
    endtask

    task automatic check_puck_view();
        // column 0 lights bit 4, the last column bit 0
        check_value("led_bar", led_bar, 32'd1 << (4 - exp_x));
        check_value("ssd.row_digit", ssd.row_digit, digit_glyph(exp_y));
    endtask

    task automatic check_scores();
        check_value("ssd.score_a_digit", ssd.score_a_digit, digit_glyph(exp_score_a));
        check_value("ssd.sep_digit", ssd.sep_digit, seg_dash);
        check_value("ssd.score_b_digit", ssd.score_b_digit, digit_glyph(exp_score_b));
    endtask

    task automatic track_puck(input int target);
        while (exp_x != target && !timed_out)
        begin
            exp_x = heading_b ? exp_x + 1 : exp_x - 1;
            row_step_model(exp_dir);
            wait_bar_change("the next puck step");
            check_puck_view();
        end
    endtask

    task automatic serve_puck(input player_t server);
        int   row;
        dir_t dir;
        row = random_bits(3) % 5;
        dir = dir_t'(random_bits(2));
        wait_leds(server == side_a, server == side_b, "the serve indication");
        if (server == side_a)
        begin
            y_a   = coord_t'(row);
            dir_a = dir;
        end
        else
        begin
            y_b   = coord_t'(row);
            dir_b = dir;
        end
        repeat (4) @(negedge clk);
        check_value("ssd.row_digit", ssd.row_digit, digit_glyph(row));
        btn_a     = (server == side_a);
        btn_b     = (server == side_b);
        exp_x     = (server == side_a) ? 0 : 4;
        exp_y     = row;
        exp_dir   = dir;
        heading_b = (server == side_a);
        wait_bar_change("the served puck");
        check_puck_view();
        btn_a = 1'b0;
        btn_b = 1'b0;
        track_puck(heading_b ? 4 : 0);
    endtask

    initial
    begin
        clk   = 1'b0;
        rst   = 1'b1;
        btn_a = 1'b0;
        btn_b = 1'b0;
        dir_a = 2'b00;
        dir_b = 2'b00;
        y_a   = 3'd0;
        y_b   = 3'd0;
        repeat (5) @(negedge clk);
        rst = 1'b0;

        @(negedge clk);
        check_value("led_a", led_a, 1'b1);
        check_value("led_b", led_b, 1'b1);
        check_value("led_bar", led_bar, 5'b00000);
        check_value("ssd", ssd, {seg_blank, seg_a, seg_dash, seg_b});
        end_test("idle");

        btn_a = 1'b1;
        wait_bar(5'b11111, "the score display");
        check_scores();
        check_value("ssd.row_digit", ssd.row_digit, seg_blank);
        btn_a = 1'b0;
        wait_leds(1'b1, 1'b0, "the serve indication of A");
        y_a = 3'd5;
        repeat (4) @(negedge clk);
        check_value("ssd.row_digit", ssd.row_digit, digit_glyph(5));
        // row 5 is off the field, so the press must do nothing
        btn_a = 1'b1;
        repeat (3 * (tick_count + 1)) @(negedge clk);
        check_value("led_a", led_a, 1'b1);
        check_value("led_bar", led_bar, 5'b00000);
        btn_a = 1'b0;
        repeat (3) @(negedge clk);
        serve_puck(side_a);
        end_test("serve");

        wait_leds(1'b0, 1'b1, "the respond indication of B");
        wait_bar(5'b11111, "the goal display");
        exp_score_a++;
        check_scores();
        end_test("miss");

        serve_puck(side_b);
        wait_bar(5'b11111, "the goal display");
        exp_score_b++;
        check_scores();
        serve_puck(side_a);
        // row must be in place before the press reaches the controller
        y_b   = coord_t'(exp_y);
        dir_b = dir_t'(random_bits(2));
        wait_leds(1'b0, 1'b1, "the respond indication of B");
        btn_b     = 1'b1;
        exp_x     = 3;
        heading_b = 1'b0;
        row_step_model(dir_b);
        wait_bar_change("the returned puck");
        check_puck_view();
        btn_b = 1'b0;
        track_puck(0);
        wait_bar(5'b11111, "the goal display");
        exp_score_b++;
        check_scores();
        end_test("return");

        wait_row_digit(seg_b, "the winner letter");
        check_scores();
        check_value("led_bar", led_bar, 5'b10101);
        btn_a = 1'b1;
        btn_b = 1'b1;
        wait_bar_change("the bar to alternate");
        check_value("led_bar", led_bar, 5'b01010);
        wait_bar_change("the bar to alternate");
        check_value("led_bar", led_bar, 5'b10101);
        check_scores();
        check_value("ssd.row_digit", ssd.row_digit, seg_b);
        btn_a = 1'b0;
        btn_b = 1'b0;
        end_test("game_over");

        sva_errors = i_hockey_top.i_hockey_sva.error_count;
        $display("checks %0d, errors %0d, assertion failures %0d", checks, errors, sva_errors);
        if (errors == 0 && sva_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire
